// File: Makefile
TOP  := arr_ctrl_tb
SRCS := $(wildcard hdl/*.sv sim/*.sv)

.PHONY: run clean

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

obj_dir/V$(TOP): sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

// File: hdl/arr_ctrl.sv
module arr_ctrl (
    input  logic                        clk,
    input  logic                        rstn,
    input  arr_pkg::mode_t              mode,
    input  logic                        data_load,
    input  logic [arr_pkg::BYTE_W-1:0]  data_in,
    output arr_pkg::lanes_t             aouts,
    output arr_pkg::lanes_t             wouts,
    output logic [arr_pkg::N_LANES-1:0] lane_vld,
    output logic                        done
);
    import arr_pkg::*;

    conv_cfg_t         cfg;
    logic              run_start;
    mem_wr_t           a_wr;
    mem_wr_t           w_wr;
    rd_req_t           rd_req;
    logic [BYTE_W-1:0] a_rd;
    logic [BYTE_W-1:0] w_rd;

    // Config, memory writes and run start
    load_ctrl u_load (
        .clk, .rstn, .mode, .data_load, .data_in,
        .cfg, .a_wr, .w_wr, .run_start
    );

    // Activations and weights
    feature_mem a_mem (
        .clk, .wr(a_wr), .rd_addr(rd_req.a_addr), .rd_data(a_rd)
    );
    feature_mem w_mem (
        .clk, .wr(w_wr), .rd_addr(rd_req.w_addr), .rd_data(w_rd)
    );

    // Window loop and address generation
    window_seq u_seq (
        .clk, .rstn, .cfg, .run_start, .rd_req
    );

    // Beat assembly and lane skew toward the array
    skew_bank u_skew (
        .clk, .rstn, .rd_req, .a_byte(a_rd), .w_byte(w_rd),
        .aouts, .wouts, .lane_vld, .done
    );

endmodule

// File: hdl/arr_pkg.sv
package arr_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Array and memory sizes
    ////////////////////////////////////////////////////////////////////////////

    // Array rows, one byte lane per row
    localparam int N_LANES = 16;
    // Kernel edge, 3x3 convolution
    localparam int KSIZE   = 3;
    localparam int BYTE_W  = 8;
    // 1024 bytes per feature memory
    localparam int MEM_AW  = 10;

    // Operating mode, same encoding as the mode pins
    typedef enum logic [1:0] {
        MODE_CFG = 2'b00,
        MODE_WGT = 2'b01,
        MODE_ACT = 2'b10,
        MODE_RUN = 2'b11
    } mode_t;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake words
    ////////////////////////////////////////////////////////////////////////////

    // Config bytes in load order, out_ch first
    typedef struct packed {
        logic [BYTE_W-1:0] out_ch;
        logic [BYTE_W-1:0] in_ch;
        logic [BYTE_W-1:0] width;
        logic [BYTE_W-1:0] height;
    } conv_cfg_t;

    // One byte write into a feature memory
    typedef struct packed {
        logic              vld;
        logic [MEM_AW-1:0] addr;
        logic [BYTE_W-1:0] data;
    } mem_wr_t;

    // Read request for one PE lane of one tap
    typedef struct packed {
        logic                       vld;
        logic [$clog2(N_LANES)-1:0] lane;
        logic [MEM_AW-1:0]          a_addr;
        logic [MEM_AW-1:0]          w_addr;
        logic                       a_zero;  // window past the last one
        logic                       w_zero;  // no kernel for this lane
        logic                       last;
    } rd_req_t;

    // Lane payload once memory data is back
    typedef struct packed {
        logic                       vld;
        logic [$clog2(N_LANES)-1:0] lane;
        logic [BYTE_W-1:0]          a_byte;
        logic [BYTE_W-1:0]          w_byte;
        logic                       last;
    } lane_data_t;

    // Lane i sits at index i
    typedef logic [N_LANES-1:0][BYTE_W-1:0] lanes_t;

endpackage

// File: hdl/feature_mem.sv
module feature_mem (
    input  logic                       clk,
    input  arr_pkg::mem_wr_t           wr,
    input  logic [arr_pkg::MEM_AW-1:0] rd_addr,
    output logic [arr_pkg::BYTE_W-1:0] rd_data
);
    import arr_pkg::*;

    // Byte array, one word per address
    logic [BYTE_W-1:0] mem [2**MEM_AW];

    // Write port, byte readable from the next cycle on
    always_ff @(posedge clk) begin
        if (wr.vld)
            mem[wr.addr] <= wr.data;
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: hdl/load_ctrl.sv
module load_ctrl (
    input  logic                       clk,
    input  logic                       rstn,
    input  arr_pkg::mode_t             mode,
    input  logic                       data_load,
    input  logic [arr_pkg::BYTE_W-1:0] data_in,
    output arr_pkg::conv_cfg_t         cfg,
    output arr_pkg::mem_wr_t           a_wr,
    output arr_pkg::mem_wr_t           w_wr,
    output logic                       run_start
);
    import arr_pkg::*;

    // Next config byte, 4 means all loaded
    logic [2:0]        cfg_idx;
    // Write pointers, count up from 0
    logic [MEM_AW-1:0] a_cnt;
    logic [MEM_AW-1:0] w_cnt;
    // Set once the single run has been issued
    logic              run_done;
    logic              cfg_ld;

    // Mode decode, strobes only act in their own mode
    always_comb begin
        cfg_ld    = data_load && (mode == MODE_CFG) && (cfg_idx < 3'd4);
        a_wr.vld  = data_load && (mode == MODE_ACT);
        a_wr.addr = a_cnt;
        a_wr.data = data_in;
        w_wr.vld  = data_load && (mode == MODE_WGT);
        w_wr.addr = w_cnt;
        w_wr.data = data_in;
        // First RUN cycle after reset
        run_start = (mode == MODE_RUN) && !run_done;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cfg_idx  <= '0;
            cfg      <= '0;
            a_cnt    <= '0;
            w_cnt    <= '0;
            run_done <= 1'b0;
        end else begin
            // Config bytes in order out_ch, in_ch, width, height
            if (cfg_ld) begin
                cfg_idx <= cfg_idx + 3'd1;
                case (cfg_idx)
                    3'd0:    cfg.out_ch <= data_in;
                    3'd1:    cfg.in_ch  <= data_in;
                    3'd2:    cfg.width  <= data_in;
                    default: cfg.height <= data_in;
                endcase
            end
            // Counter moves after the byte has gone out at the old address
            if (a_wr.vld)
                a_cnt <= a_cnt + 1'b1;
            if (w_wr.vld)
                w_cnt <= w_cnt + 1'b1;
            if (run_start)
                run_done <= 1'b1;
        end
    end

endmodule

// File: hdl/skew_bank.sv
module skew_bank (
    input  logic                        clk,
    input  logic                        rstn,
    input  arr_pkg::rd_req_t            rd_req,
    input  logic [arr_pkg::BYTE_W-1:0]  a_byte,
    input  logic [arr_pkg::BYTE_W-1:0]  w_byte,
    output arr_pkg::lanes_t             aouts,
    output arr_pkg::lanes_t             wouts,
    output logic [arr_pkg::N_LANES-1:0] lane_vld,
    output logic                        done
);
    import arr_pkg::*;

    // Request flags, one cycle late to meet the read data
    logic       q_vld;
    logic [3:0] q_lane;
    logic       q_az;
    logic       q_wz;
    logic       q_last;
    lane_data_t cur;
    logic       beat_end;
    // Collect stage, full beat and release stage
    lanes_t     col_a;
    lanes_t     col_w;
    lanes_t     beat_a;
    lanes_t     beat_w;
    lanes_t     rel_a;
    lanes_t     rel_w;
    logic       fin_pend;   // last beat is being released

    always_ff @(posedge clk) begin
        if (!rstn) begin
            {q_vld, q_lane, q_az, q_wz, q_last} <= '0;
        end else begin
            q_vld  <= rd_req.vld;
            q_lane <= rd_req.lane;
            q_az   <= rd_req.a_zero;
            q_wz   <= rd_req.w_zero;
            q_last <= rd_req.last;
        end
    end

    // Flagged lanes become 0
    always_comb begin
        cur.vld    = q_vld;
        cur.lane   = q_lane;
        cur.a_byte = q_az ? '0 : a_byte;
        cur.w_byte = q_wz ? '0 : w_byte;
        cur.last   = q_last;
        // Lane 15 goes straight into the beat
        beat_a = col_a;
        beat_w = col_w;
        beat_a[N_LANES-1] = cur.a_byte;
        beat_w[N_LANES-1] = cur.w_byte;
    end

    assign beat_end = cur.vld && (cur.lane == 4'(N_LANES - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Collect, release and staggered output
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (cur.vld) begin
            col_a[cur.lane] <= cur.a_byte;
            col_w[cur.lane] <= cur.w_byte;
        end
        if (beat_end) begin
            rel_a    <= beat_a;
            rel_w    <= beat_w;
            aouts[0] <= beat_a[0];
            wouts[0] <= beat_w[0];
        end
        // Lane i follows lane i-1 by one cycle
        for (int i = 1; i < N_LANES; i++) begin
            if (lane_vld[i-1]) begin
                aouts[i] <= rel_a[i];
                wouts[i] <= rel_w[i];
            end
        end
    end

    // Strobe chain, done sticks after lane 15 of the last beat
    always_ff @(posedge clk) begin
        if (!rstn) begin
            lane_vld <= '0;
            fin_pend <= 1'b0;
            done     <= 1'b0;
        end else begin
            lane_vld <= {lane_vld[N_LANES-2:0], beat_end};
            fin_pend <= fin_pend | (beat_end & cur.last);
            done     <= done | (fin_pend & lane_vld[N_LANES-1]);
        end
    end

endmodule

// File: hdl/window_seq.sv
module window_seq (
    input  logic               clk,
    input  logic               rstn,
    input  arr_pkg::conv_cfg_t cfg,
    input  logic               run_start,
    output arr_pkg::rd_req_t   rd_req
);
    import arr_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Derived sizes
    ////////////////////////////////////////////////////////////////////////////

    logic [BYTE_W-1:0] row_w;      // windows per row
    logic [15:0]       win_cnt;    // windows per channel
    logic [15:0]       grp_sum;
    logic [11:0]       grp_cnt;    // groups of 16 windows, rounded up
    logic [15:0]       ch_stride;  // bytes per input channel
    logic [15:0]       w_stride;   // bytes per kernel

    assign row_w     = cfg.width - 8'd2;
    assign win_cnt   = 16'(row_w) * 16'(cfg.height - 8'd2);
    assign grp_sum   = win_cnt + 16'd15;
    assign grp_cnt   = grp_sum[15:4];
    assign ch_stride = 16'(cfg.width) * 16'(cfg.height);
    assign w_stride  = 16'(KSIZE * KSIZE) * 16'(cfg.in_ch);

    ////////////////////////////////////////////////////////////////////////////
    // Loop counters
    ////////////////////////////////////////////////////////////////////////////

    logic              active;
    logic [3:0]        p;          // PE lane, innermost
    logic [1:0]        k;          // kernel column
    logic [1:0]        r;          // kernel row
    logic [BYTE_W-1:0] c;          // input channel
    logic [11:0]       g;          // window group, outermost
    // Window position of n = g*16+p, and of the group's first window
    logic [BYTE_W-1:0] cur_col;
    logic [BYTE_W-1:0] cur_row;
    logic [BYTE_W-1:0] grp_col;
    logic [BYTE_W-1:0] grp_row;
    logic [BYTE_W-1:0] nxt_col;
    logic [BYTE_W-1:0] nxt_row;
    logic              tap_end;
    logic              grp_end;
    logic              is_last;
    logic [15:0]       n;
    logic [15:0]       a_full;
    logic [15:0]       w_full;

    // Next window in raster order
    always_comb begin
        if (cur_col == row_w - 8'd1) begin
            nxt_col = '0;
            nxt_row = cur_row + 8'd1;
        end else begin
            nxt_col = cur_col + 8'd1;
            nxt_row = cur_row;
        end
    end

    assign tap_end = (p == 4'(N_LANES - 1));
    assign grp_end = tap_end && (k == 2'(KSIZE - 1)) && (r == 2'(KSIZE - 1))
                     && (c == cfg.in_ch - 8'd1);
    assign is_last = grp_end && (g == grp_cnt - 12'd1);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            active  <= 1'b0;
            {p, k, r, c, g} <= '0;
            {cur_col, cur_row, grp_col, grp_row} <= '0;
        end else if (run_start) begin
            active  <= 1'b1;
            {p, k, r, c, g} <= '0;
            {cur_col, cur_row, grp_col, grp_row} <= '0;
        end else if (active) begin
            p <= p + 4'd1;
            if (!tap_end) begin
                cur_col <= nxt_col;
                cur_row <= nxt_row;
            end else if (!grp_end) begin
                // Same windows again for the next tap
                cur_col <= grp_col;
                cur_row <= grp_row;
                if (k == 2'(KSIZE - 1)) begin
                    k <= '0;
                    if (r == 2'(KSIZE - 1)) begin
                        r <= '0;
                        c <= c + 8'd1;
                    end else begin
                        r <= r + 2'd1;
                    end
                end else begin
                    k <= k + 2'd1;
                end
            end else begin
                // Group done, window after lane 15 starts the next one
                grp_col <= nxt_col;
                grp_row <= nxt_row;
                cur_col <= nxt_col;
                cur_row <= nxt_row;
                {k, r, c} <= '0;
                g <= g + 12'd1;
                if (is_last)
                    active <= 1'b0;
            end
        end
    end

    // Address generation
    assign n      = {g, p};
    assign a_full = 16'(c) * ch_stride + (16'(cur_row) + 16'(r)) * 16'(cfg.width)
                    + 16'(cur_col) + 16'(k);
    assign w_full = 16'(p) * w_stride + 16'(c) * 16'(KSIZE * KSIZE)
                    + 16'(r) * 16'(KSIZE) + 16'(k);

    always_comb begin
        rd_req.vld    = active;
        rd_req.lane   = p;
        rd_req.a_addr = a_full[MEM_AW-1:0];
        rd_req.w_addr = w_full[MEM_AW-1:0];
        rd_req.a_zero = (n >= win_cnt);
        rd_req.w_zero = ({4'd0, p} >= cfg.out_ch);
        rd_req.last   = active && is_last;
    end

endmodule

// File: sim.f
hdl/arr_pkg.sv
hdl/load_ctrl.sv
hdl/feature_mem.sv
hdl/window_seq.sv
hdl/skew_bank.sv
hdl/arr_ctrl.sv
sim/tb_clkgen.sv
sim/arr_ctrl_props.sv
sim/arr_ctrl_tb.sv

// File: sim/arr_ctrl_props.sv
module arr_ctrl_props (
    input logic                        clk,
    input logic                        rstn,
    input logic [arr_pkg::N_LANES-1:0] lane_vld,
    input logic                        done
);
    import arr_pkg::*;

    // Strobe walks one lane up per cycle
    for (genvar i = 0; i < N_LANES - 1; i++) begin : g_skew
        a_skew: assert property (@(posedge clk) disable iff (!rstn)
            lane_vld[i] |=> lane_vld[i+1])
            else $error("lane_vld[%0d] not followed by lane_vld[%0d]", i, i + 1);
    end

    // done is sticky until reset
    a_done_hold: assert property (@(posedge clk) disable iff (!rstn) done |=> done)
        else $error("done dropped before reset");

    // Outputs quiet while reset is held
    a_rst_quiet: assert property (@(posedge clk) !rstn |=> (lane_vld == '0))
        else $error("lane_vld high during reset");

endmodule

bind arr_ctrl arr_ctrl_props u_props (.clk, .rstn, .lane_vld, .done);

// File: sim/arr_ctrl_tb.sv
module arr_ctrl_tb;
    import arr_pkg::*;

    localparam int N_TESTS = 5;
    // out_ch, in_ch, width, height per test
    localparam conv_cfg_t CFGS [N_TESTS] = '{
        32'h03010505, 32'h10020605, 32'h10010806, 32'h05010606, 32'h10030504
    };

    logic               clk;
    logic               rstn;
    mode_t              mode;
    logic               data_load;
    logic [BYTE_W-1:0]  data_in;
    lanes_t             aouts;
    lanes_t             wouts;
    logic [N_LANES-1:0] lane_vld;
    logic               done;

    tb_clkgen u_clk (.clk);

    arr_ctrl DUT (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////////////////////////////////////////

    int                seed = 32'h30795b69;
    int                errors = 0;
    int                test_errs;
    int                tests_run = 0;
    string             test_name = "init";
    conv_cfg_t         ecfg;
    logic [BYTE_W-1:0] act_m [1024];
    logic [BYTE_W-1:0] wgt_m [1024];
    // Beats seen per lane, and lane-0 cycle of every beat
    int                lane_cnt [N_LANES];
    int                t0 [$];
    int                cyc = 0;
    int                last15 = 0;
    logic              done_q = 1'b0;

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    function automatic int beat_count(input conv_cfg_t c);
        int win;
        win = (c.width - 2) * (c.height - 2);
        return (win + 15) / 16 * 9 * c.in_ch;
    endfunction

    function automatic int run_cycles(input conv_cfg_t c);
        return beat_count(c) * 16 + 40;
    endfunction

    function automatic int load_cycles(input conv_cfg_t c);
        return 16 + 6 + c.out_ch * 9 * c.in_ch + c.in_ch * c.width * c.height;
    endfunction

    // Expected byte of lane p in beat b from the address rules
    function automatic logic [BYTE_W-1:0] exp_byte(input int b, input int p, input bit wgt);
        int taps, t, c, r, k, n, rw;
        taps = 9 * ecfg.in_ch;
        t = b % taps;
        c = t / 9;
        r = (t % 9) / 3;
        k = t % 3;
        n = (b / taps) * 16 + p;
        rw = ecfg.width - 2;
        if (wgt)
            return (p >= ecfg.out_ch) ? '0 : wgt_m[p * taps + t];
        if (n >= rw * (ecfg.height - 2))
            return '0;
        return act_m[c * ecfg.width * ecfg.height + (n / rw + r) * ecfg.width + n % rw + k];
    endfunction

    always @(posedge clk)
        cyc <= cyc + 1;

    // Lane monitor samples at the falling edge where outputs are settled
    always @(negedge clk) begin
        if (rstn) begin
            for (int i = 0; i < N_LANES; i++) begin
                if (lane_vld[i]) begin
                    if (i == 0 && t0.size() > 0)
                        check("lane0 spacing", 16, cyc - t0[$]);
                    if (i == 0)
                        t0.push_back(cyc);
                    // Higher lanes trail the lane-0 strobe of their own beat
                    if (i > 0) begin
                        if (lane_cnt[i] < t0.size()) begin
                            check($sformatf("lane%0d skew", i), i, cyc - t0[lane_cnt[i]]);
                        end else begin
                            errors++;
                            $display("%s: lane%0d strobed with no lane0 strobe before it",
                                     test_name, i);
                        end
                    end
                    check($sformatf("aouts[%0d] beat %0d", i, lane_cnt[i]),
                          exp_byte(lane_cnt[i], i, 1'b0), aouts[i]);
                    check($sformatf("wouts[%0d] beat %0d", i, lane_cnt[i]),
                          exp_byte(lane_cnt[i], i, 1'b1), wouts[i]);
                    if (i == N_LANES - 1)
                        last15 = cyc;
                    lane_cnt[i]++;
                end
            end
            if (done && !done_q)
                check("done rise", last15 + 1, cyc);
            done_q = done;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_dut();
        @(negedge clk);
        rstn = 1'b0;
        mode = MODE_CFG;
        data_load = 1'b0;
        data_in = '0;
        repeat (16) @(negedge clk);
        t0.delete();
        foreach (lane_cnt[i])
            lane_cnt[i] = 0;
        last15 = 0;
        done_q = 1'b0;
        rstn = 1'b1;
    endtask

    // One data_load strobe starting on a falling edge
    task automatic strobe(input mode_t m, input logic [BYTE_W-1:0] b);
        mode = m;
        data_load = 1'b1;
        data_in = b;
        @(negedge clk);
        data_load = 1'b0;
    endtask

    task automatic run_conv(input int idx, input bit extra_cfg);
        int                limit;
        logic [BYTE_W-1:0] b;
        reset_dut();
        ecfg = CFGS[idx];
        strobe(MODE_CFG, ecfg.out_ch);
        strobe(MODE_CFG, ecfg.in_ch);
        strobe(MODE_CFG, ecfg.width);
        strobe(MODE_CFG, ecfg.height);
        // Fifth byte must be dropped
        if (extra_cfg)
            strobe(MODE_CFG, 8'hff);
        for (int a = 0; a < ecfg.out_ch * 9 * ecfg.in_ch; a++) begin
            b = 8'($random(seed));
            wgt_m[a] = b;
            strobe(MODE_WGT, b);
        end
        for (int a = 0; a < ecfg.in_ch * ecfg.width * ecfg.height; a++) begin
            b = 8'($random(seed));
            act_m[a] = b;
            strobe(MODE_ACT, b);
        end
        mode = MODE_RUN;
        limit = run_cycles(ecfg);
        while (!done && limit > 0) begin
            @(negedge clk);
            limit--;
        end
        if (!done) begin
            errors++;
            $display("%s: done did not rise within %0d cycles of run", test_name,
                     run_cycles(ecfg));
        end
        check("lane0 strobes", beat_count(ecfg), lane_cnt[0]);
        check("lane15 strobes", beat_count(ecfg), lane_cnt[N_LANES-1]);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        tests_run++;
        $display("%s %s", test_name, (errors == test_errs) ? "ok" : "FAILED");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic cfg_and_load();
        begin_test("cfg_and_load");
        run_conv(0, 1'b1);
        check("cfg bytes", CFGS[0], DUT.u_load.cfg);
        end_test();
    endtask

    // 12 windows so lanes 12..15 of aouts stay zero
    task automatic single_group();
        begin_test("single_group");
        run_conv(1, 1'b0);
        end_test();
    endtask

    task automatic two_groups();
        begin_test("two_groups");
        run_conv(2, 1'b0);
        end_test();
    endtask

    // With out_ch 5 the wouts lanes 5..15 stay zero
    task automatic weight_lanes();
        begin_test("weight_lanes");
        run_conv(3, 1'b0);
        end_test();
    endtask

    task automatic skew_and_done();
        begin_test("skew_and_done");
        run_conv(4, 1'b0);
        repeat (20) @(negedge clk);
        check("done held", 1, done);
        end_test();
    endtask

    initial begin
        rstn = 1'b0;
        mode = MODE_CFG;
        data_load = 1'b0;
        data_in = '0;
        cfg_and_load();
        single_group();
        two_groups();
        weight_lanes();
        skew_and_done();
        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // Watchdog at twice the load and run time of all tests
    initial begin
        int limit;
        limit = 0;
        for (int i = 0; i < N_TESTS; i++)
            limit += load_cycles(CFGS[i]) + run_cycles(CFGS[i]);
        repeat (2 * limit) @(posedge clk);
        $display("Watchdog: the run did not finish within %0d cycles", 2 * limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: sim/tb_clkgen.sv
module tb_clkgen (
    output logic clk
);
    // 10 unit period, first rising edge at 5
    initial clk = 1'b0;

    always #5 clk = ~clk;

endmodule
